/* mtx_pkg.sv */
/*
 * shared widths and sizes for the link transmitter
 * imported by every transmitter module
 */
package mtx_pkg;

   //########################################
   //# pin side
   //########################################

   // io data pins, one half-word per pin beat
   localparam int NMIO = 16;

   // io word, two half-words
   localparam int IOW = 2 * NMIO;

   //########################################
   //# core side
   //########################################

   // core transaction, passed through opaque
   localparam int TW = 64;

   // io words per transaction, upper word sent first
   localparam int NWORDS = TW / IOW;

   // entries per channel fifo
   localparam int FIFO_DEPTH = 4;

   // channel count
   // channel 0 carries writes, channel 1 carries reads
   localparam int NCH = 2;

endpackage

/* mtx_fifo.sv */
/*
 * channel transaction fifo, one per core channel
 * raises wait_out toward the core while full
 */
`timescale 1ns/1ps

module mtx_fifo
   import mtx_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH
) (
   input  logic          io_clk,
   input  logic          io_nreset,
   input  logic          access,
   input  logic [TW-1:0] packet,
   output logic          wait_out,
   input  logic          pop,
   output logic          not_empty,
   output logic [TW-1:0] head
);

   // storage
   logic [TW-1:0] mem [DEPTH];

   // pointers and occupancy
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       full;
   logic                       wr_en;

   assign full      = (count == DEPTH);
   assign wr_en     = access & ~full;
   assign wait_out  = full;
   assign not_empty = (count != 0);
   assign head      = mem[rd_ptr];

   //########################################
   //# pointers
   //########################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // wrap at depth
         if (wr_en) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy, push and pop together leave it unchanged
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // write port
   always_ff @(posedge io_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= packet;
      end
   end

   //########################################
   //# checks
   //########################################

   // arbiter only pops a channel that holds data
   a_no_pop_empty: assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      pop |-> not_empty
   );

   // core holds the write while full, so nothing is dropped
   a_hold_while_full: assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      (access && wait_out) |=> (access && $stable(packet))
   );

endmodule

/* mtx_arbiter.sv */
/*
 * round-robin grant of the write and read fifos onto the serializer
 * hands off one head per cycle when the serializer is idle
 */
`timescale 1ns/1ps

module mtx_arbiter
   import mtx_pkg::*;
(
   input  logic                    io_clk,
   input  logic                    io_nreset,
   input  logic [NCH-1:0]          not_empty,
   input  logic [NCH-1:0][TW-1:0]  heads,
   input  logic                    busy,
   output logic [NCH-1:0]          pop,
   output logic                    req_valid,
   output logic [TW-1:0]           req_packet,
   output logic [NCH-1:0]          grant
);

   // last served channel
   logic last_ch;
   // channel picked this cycle
   logic sel_ch;
   logic handoff;

   // favour the channel not served last, else fall back
   always_comb begin
      sel_ch = ~last_ch;
      if (!not_empty[~last_ch]) begin
         sel_ch = last_ch;
      end
   end

   always_comb begin
      grant         = '0;
      grant[sel_ch] = req_valid;
   end

   assign req_valid  = |not_empty;
   assign req_packet = heads[sel_ch];
   assign handoff    = req_valid & ~busy;

   // pop the granted fifo on handoff
   assign pop = grant & {NCH{handoff}};

   // pointer starts on read so write goes first
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         last_ch <= 1'b1;
      end else if (handoff) begin
         last_ch <= sel_ch;
      end
   end

   // serializer takes one transaction per handoff
   a_one_handoff: assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      handoff |=> !handoff
   );

endmodule

/* mtx_serializer.sv */
/*
 * cuts a granted transaction into io words, upper word first
 * busy from handoff until the last word is taken by the io block
 */
`timescale 1ns/1ps

module mtx_serializer
   import mtx_pkg::*;
(
   input  logic           io_clk,
   input  logic           io_nreset,
   input  logic           req_valid,
   input  logic [TW-1:0]  req_packet,
   output logic           busy,
   input  logic           io_wait,
   output logic           io_access,
   output logic [IOW-1:0] io_packet
);

   // held transaction
   logic [TW-1:0] pkt;

   // word state
   logic                        active;
   logic [$clog2(NWORDS)-1:0]   word_idx;
   logic                        consume;
   logic                        last_word;

   assign busy      = active;
   assign io_access = active;
   assign consume   = active & ~io_wait;
   assign last_word = (word_idx == NWORDS - 1);

   // word 0 is the top slice
   assign io_packet = pkt[(NWORDS - 1 - word_idx) * IOW +: IOW];

   //########################################
   //# word sequencing
   //########################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         active   <= 1'b0;
         word_idx <= '0;
      end else if (!active) begin
         // handoff from arbiter
         active   <= req_valid;
         word_idx <= '0;
      end else if (consume) begin
         if (last_word) begin
            active   <= 1'b0;
            word_idx <= '0;
         end else begin
            word_idx <= word_idx + 1'b1;
         end
      end
   end

   // capture on handoff
   always_ff @(posedge io_clk) begin
      if (req_valid && !active) begin
         pkt <= req_packet;
      end
   end

   // io word holds while the io block stalls it
   a_stable_on_wait: assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      (io_access && io_wait) |=> (io_access && $stable(io_packet))
   );

endmodule

/* mtx_io.sv */
/*
 * pin side io logic, sdr half-word selector and behavioural ddr stage
 * io_wait stalls the serializer per half-word in sdr and on tx_wait
 */
`timescale 1ns/1ps

module mtx_io
   import mtx_pkg::*;
(
   input  logic            nreset,
   input  logic            io_clk,
   input  logic            ddr_mode,
   input  logic            lsbfirst,
   output logic [NMIO-1:0] tx_packet,
   output logic            tx_access,
   input  logic            tx_wait,
   input  logic            io_access,
   input  logic [IOW-1:0]  io_packet,
   output logic            io_wait
);

   // local reset
   logic [1:0] rst_sync;
   logic       io_nreset;

   // half-word order
   logic [NMIO-1:0] first_half;
   logic [NMIO-1:0] second_half;
   logic            send;

   // sdr path
   logic            half_sel;
   logic [NMIO-1:0] tx_packet_sdr;

   // ddr path
   logic [NMIO-1:0] ddr_rise;
   logic [NMIO-1:0] ddr_fall_p;
   logic [NMIO-1:0] ddr_fall_n;
   logic [NMIO-1:0] tx_packet_ddr;

   //########################################
   //# reset synchronizer
   //########################################

   // async assert, sync release
   always_ff @(posedge io_clk or negedge nreset) begin
      if (!nreset) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign io_nreset = rst_sync[1];

   //########################################
   //# access strobe
   //########################################

   // a half-word leaves only when the pins are not stalled
   assign send = io_access & ~tx_wait;

   // pin strobe, one cycle behind io_access
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         tx_access <= 1'b0;
      end else begin
         tx_access <= send;
      end
   end

   // lsbfirst swaps halves within each io word
   assign first_half  = lsbfirst ? io_packet[NMIO-1:0] : io_packet[IOW-1:NMIO];
   assign second_half = lsbfirst ? io_packet[IOW-1:NMIO] : io_packet[NMIO-1:0];

   //########################################
   //# sdr half-word selector
   //########################################

   // 0 while the first half goes out
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         half_sel <= 1'b0;
      end else if (ddr_mode || !io_access) begin
         half_sel <= 1'b0;
      end else if (!tx_wait) begin
         half_sel <= ~half_sel;
      end
   end

   always_ff @(posedge io_clk) begin
      if (send) begin
         tx_packet_sdr <= half_sel ? second_half : first_half;
      end
   end

   // hold the word through its first half in sdr
   assign io_wait = tx_wait | (~ddr_mode & io_access & ~half_sel);

   //########################################
   //# ddr output stage
   //########################################

   // both halves on the rising edge
   always_ff @(posedge io_clk) begin
      if (send) begin
         ddr_rise   <= first_half;
         ddr_fall_p <= second_half;
      end
   end

   // second half retimed for the low phase
   always_ff @(negedge io_clk) begin
      ddr_fall_n <= ddr_fall_p;
   end

   // high phase first half, low phase second half
   assign tx_packet_ddr = io_clk ? ddr_rise : ddr_fall_n;

   assign tx_packet = ddr_mode ? tx_packet_ddr : tx_packet_sdr;

endmodule

/* mtx_top.sv */
/*
 * link transmitter top, write and read channels onto one pin bus
 * core side uses access/packet/wait per channel
 */
`timescale 1ns/1ps

module mtx_top
   import mtx_pkg::*;
(
   input  logic            io_clk,
   input  logic            io_nreset,
   input  logic            ddr_mode,
   input  logic            lsbfirst,
   input  logic            wr_access,
   input  logic [TW-1:0]   wr_packet,
   output logic            wr_wait,
   input  logic            rd_access,
   input  logic [TW-1:0]   rd_packet,
   output logic            rd_wait,
   output logic [NMIO-1:0] tx_packet,
   output logic            tx_access,
   input  logic            tx_wait
);

   // fifo to arbiter, index 0 write, index 1 read
   logic [NCH-1:0]         fifo_not_empty;
   logic [NCH-1:0][TW-1:0] fifo_heads;
   logic [NCH-1:0]         fifo_pop;

   // arbiter to serializer
   logic          req_valid;
   logic [TW-1:0] req_packet;
   logic          busy;

   // serializer to io
   logic           io_access;
   logic [IOW-1:0] io_packet;
   logic           io_wait;

   mtx_fifo u_wr_fifo (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .access    (wr_access),
      .packet    (wr_packet),
      .wait_out  (wr_wait),
      .pop       (fifo_pop[0]),
      .not_empty (fifo_not_empty[0]),
      .head      (fifo_heads[0])
   );

   mtx_fifo u_rd_fifo (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .access    (rd_access),
      .packet    (rd_packet),
      .wait_out  (rd_wait),
      .pop       (fifo_pop[1]),
      .not_empty (fifo_not_empty[1]),
      .head      (fifo_heads[1])
   );

   mtx_arbiter u_arbiter (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .not_empty  (fifo_not_empty),
      .heads      (fifo_heads),
      .busy       (busy),
      .pop        (fifo_pop),
      .req_valid  (req_valid),
      .req_packet (req_packet),
      .grant      ()
   );

   mtx_serializer u_serializer (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .req_valid  (req_valid),
      .req_packet (req_packet),
      .busy       (busy),
      .io_wait    (io_wait),
      .io_access  (io_access),
      .io_packet  (io_packet)
   );

   mtx_io u_io (
      .nreset    (io_nreset),
      .io_clk    (io_clk),
      .ddr_mode  (ddr_mode),
      .lsbfirst  (lsbfirst),
      .tx_packet (tx_packet),
      .tx_access (tx_access),
      .tx_wait   (tx_wait),
      .io_access (io_access),
      .io_packet (io_packet),
      .io_wait   (io_wait)
   );

endmodule

/* tb_mtx.sv */
/*
 * directed testbench for the link transmitter
 * feeds both core channels, collects pin half-words, checks order and timing
 */
`timescale 1ns/1ps

module tb_mtx
   import mtx_pkg::*;
();

   localparam int PERIOD     = 100;
   localparam int MAX_CYCLES = 2000;

   // dut ports
   logic            io_clk;
   logic            io_nreset;
   logic            ddr_mode;
   logic            lsbfirst;
   logic            wr_access;
   logic [TW-1:0]   wr_packet;
   logic            wr_wait;
   logic            rd_access;
   logic [TW-1:0]   rd_packet;
   logic            rd_wait;
   logic [NMIO-1:0] tx_packet;
   logic            tx_access;
   logic            tx_wait;

   // pin half-words with sample times, and what should arrive
   logic [NMIO-1:0] rx_q [$];
   time             rx_t [$];
   logic [NMIO-1:0] exp_q [$];
   int              cycles = 0;

   mtx_top UUT (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .ddr_mode  (ddr_mode),
      .lsbfirst  (lsbfirst),
      .wr_access (wr_access),
      .wr_packet (wr_packet),
      .wr_wait   (wr_wait),
      .rd_access (rd_access),
      .rd_packet (rd_packet),
      .rd_wait   (rd_wait),
      .tx_packet (tx_packet),
      .tx_access (tx_access),
      .tx_wait   (tx_wait)
   );

   initial begin
      io_clk = 1'b0;
      forever #(PERIOD / 2) io_clk = ~io_clk;
   end

   // run limit
   always @(posedge io_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
         abort_run();
      end
   end

   //########################################
   //# pin monitor
   //########################################

   // sdr, one half-word per clock
   always @(posedge io_clk) begin
      if (!ddr_mode && tx_access) begin
         rx_q.push_back(tx_packet);
         rx_t.push_back($time);
      end
   end

   // ddr, mid high phase then mid low phase
   always @(posedge io_clk) begin
      #(PERIOD / 4);
      if (ddr_mode && tx_access) begin
         rx_q.push_back(tx_packet);
         rx_t.push_back($time);
      end
      #(PERIOD / 2);
      if (ddr_mode && tx_access) begin
         rx_q.push_back(tx_packet);
         rx_t.push_back($time);
      end
   end

   //########################################
   //# helpers
   //########################################

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [TW-1:0] got,
                              input logic [TW-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // pin order: upper io word first, halves swapped by lsbfirst
   function automatic void expect_txn(input logic [TW-1:0] pkt, input logic lsb);
      logic [IOW-1:0] word;
      for (int w = 0; w < NWORDS; w++) begin
         word = pkt[TW - 1 - w * IOW -: IOW];
         if (lsb) begin
            exp_q.push_back(word[NMIO-1:0]);
            exp_q.push_back(word[IOW-1:NMIO]);
         end else begin
            exp_q.push_back(word[IOW-1:NMIO]);
            exp_q.push_back(word[NMIO-1:0]);
         end
      end
   endfunction

   function automatic void start_stream();
      rx_q.delete();
      rx_t.delete();
      exp_q.delete();
   endfunction

   task automatic reset_dut();
      io_nreset = 1'b0;
      wr_access = 1'b0;
      rd_access = 1'b0;
      tx_wait   = 1'b0;
      repeat (10) @(posedge io_clk);
      #5;
      io_nreset = 1'b1;
      // two-flop reset synchronizer in the io block
      repeat (2) @(posedge io_clk);
      #5;
   endtask

   // one transaction on a channel, held while wait is high
   task automatic offer(input int ch, input logic [TW-1:0] pkt, output time t_acc);
      logic stalled;
      if (ch == 0) begin
         wr_access = 1'b1;
         wr_packet = pkt;
      end else begin
         rd_access = 1'b1;
         rd_packet = pkt;
      end
      // wait looked at mid-cycle, taken on the next edge once low
      stalled = (ch == 0) ? wr_wait : rd_wait;
      while (stalled) begin
         @(posedge io_clk);
         #5;
         stalled = (ch == 0) ? wr_wait : rd_wait;
      end
      @(posedge io_clk);
      t_acc = $time;
      #5;
      if (ch == 0) begin
         wr_access = 1'b0;
      end else begin
         rd_access = 1'b0;
      end
   endtask

   task automatic wait_and_compare(input string what);
      while (rx_q.size() < exp_q.size()) begin
         @(posedge io_clk);
         #5;
      end
      // pins idle, so any extra half-word is already caught
      do begin
         @(posedge io_clk);
         #5;
      end while (tx_access);
      check_value({what, " half-word count"}, rx_q.size(), exp_q.size());
      foreach (exp_q[i]) check_value({what, " tx_packet"}, rx_q[i], exp_q[i]);
   endtask

   //########################################
   //# tests
   //########################################

   task automatic reset_test();
      check_value("tx_access", tx_access, 0);
      check_value("wr_wait", wr_wait, 0);
      check_value("rd_wait", rd_wait, 0);
   endtask

   task automatic sdr_msb_first_test();
      logic [TW-1:0] pkt;
      time           t_acc;
      start_stream();
      ddr_mode = 1'b0;
      lsbfirst = 1'b0;
      pkt = {$urandom, $urandom};
      expect_txn(pkt, 1'b0);
      offer(0, pkt, t_acc);
      wait_and_compare("sdr msb first");
      // fifo, serializer and io register
      check_value("first half-word latency", (rx_t[0] - t_acc) / PERIOD, 3);
      for (int k = 1; k < rx_t.size(); k++) begin
         check_value("sdr half-word spacing", rx_t[k] - rx_t[k-1], PERIOD);
      end
   endtask

   task automatic sdr_lsb_first_test();
      logic [TW-1:0] pkt;
      time           t_acc;
      start_stream();
      lsbfirst = 1'b1;
      for (int i = 0; i < 2; i++) begin
         pkt = {$urandom, $urandom};
         expect_txn(pkt, 1'b1);
         offer(0, pkt, t_acc);
      end
      wait_and_compare("sdr lsb first");
      lsbfirst = 1'b0;
   endtask

   task automatic ddr_test();
      logic [TW-1:0] pkt;
      time           t_acc;
      ddr_mode = 1'b1;
      for (int lsb = 0; lsb < 2; lsb++) begin
         start_stream();
         lsbfirst = lsb[0];
         for (int i = 0; i < 2; i++) begin
            pkt = {$urandom, $urandom};
            expect_txn(pkt, lsb[0]);
            offer(0, pkt, t_acc);
         end
         wait_and_compare("ddr");
         // second io word one clock after the first
         for (int k = 0; k + 2 < rx_t.size(); k += 4) begin
            check_value("ddr word spacing", rx_t[k+2] - rx_t[k], PERIOD);
         end
      end
      ddr_mode = 1'b0;
      lsbfirst = 1'b0;
   endtask

   task automatic arbitration_test();
      logic [TW-1:0] wr_pkts [4];
      logic [TW-1:0] rd_pkts [4];
      time           t_wr;
      time           t_rd;
      reset_dut();
      start_stream();
      foreach (wr_pkts[i]) begin
         wr_pkts[i] = {$urandom, $urandom};
         rd_pkts[i] = {$urandom, $urandom};
         // write goes first after reset, then strict alternation
         expect_txn(wr_pkts[i], 1'b0);
         expect_txn(rd_pkts[i], 1'b0);
      end
      fork
         foreach (wr_pkts[i]) offer(0, wr_pkts[i], t_wr);
         foreach (rd_pkts[i]) offer(1, rd_pkts[i], t_rd);
      join
      wait_and_compare("arbitration");
   endtask

   task automatic backpressure_test();
      logic [TW-1:0] pkts [8];
      time           t_acc;
      int            n_acc;
      reset_dut();
      start_stream();
      tx_wait = 1'b1;
      n_acc   = 0;
      foreach (pkts[i]) begin
         pkts[i] = {$urandom, $urandom};
         expect_txn(pkts[i], 1'b0);
      end
      fork
         begin
            foreach (pkts[i]) begin
               offer(0, pkts[i], t_acc);
               n_acc++;
            end
         end
         begin
            do begin
               @(posedge io_clk);
               #20;
            end while (!wr_wait);
            // full fifo plus one held in the serializer
            check_value("accepted before wr_wait", n_acc, FIFO_DEPTH + 1);
            check_value("half-words under tx_wait", rx_q.size(), 0);
            @(posedge io_clk);
            #5;
            tx_wait = 1'b0;
         end
      join
      wait_and_compare("back-pressure");
   endtask

   //########################################
   //# main sequence
   //########################################

   initial begin
      void'($urandom(12));
      io_nreset = 1'b0;
      ddr_mode  = 1'b0;
      lsbfirst  = 1'b0;
      wr_access = 1'b0;
      wr_packet = '0;
      rd_access = 1'b0;
      rd_packet = '0;
      tx_wait   = 1'b0;
      reset_dut();
      reset_test();
      sdr_msb_first_test();
      sdr_lsb_first_test();
      ddr_test();
      arbitration_test();
      backpressure_test();
      $display("Regression passed");
      $finish;
   end

endmodule

/* vlog.f */
mtx_pkg.sv
mtx_fifo.sv
mtx_arbiter.sv
mtx_serializer.sv
mtx_io.sv
mtx_top.sv
tb_mtx.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mtx
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
